// File: udp_tx_top.f
+incdir+.
udp_tx_pkg.sv
udp_hdr_capture.sv
ip_checksum.sv
frame_serializer.sv
udp_tx_top.sv
tb_udp_tx.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_udp_tx
FILELIST  ?= udp_tx_top.f

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_udp_tx.sv
`timescale 1ns/100ps

module tb_udp_tx;

    localparam int NUM_FRAMES = 6;
    localparam int MAX_LEN = 1023;
    localparam int HDR_BYTES = 42;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (HDR_BYTES + MAX_LEN) * 4 + 100;

    logic                      clk;
    logic                      rst;
    logic                      hdr_valid;
    logic                      hdr_ready;
    udp_tx_pkg::ip_addr_t      hdr_dest_ip;
    udp_tx_pkg::udp_port_t     hdr_dest_port;
    udp_tx_pkg::payload_len_t  hdr_length;
    logic                      pay_valid;
    logic                      pay_ready;
    udp_tx_pkg::byte_t         pay_data;
    logic                      pay_last;
    logic                      out_valid;
    logic                      out_ready;
    udp_tx_pkg::byte_t         out_data;
    logic                      out_last;

    int seed;
    int errors;
    int bytes_checked;
    int frames_out;
    int frame_byte;
    int hdr_idx;
    int pay_pos;
    int overlap_cnt;
    bit pay_took;

    udp_tx_pkg::ip_addr_t      f_ip [NUM_FRAMES];
    udp_tx_pkg::udp_port_t     f_port [NUM_FRAMES];
    udp_tx_pkg::payload_len_t  f_len [NUM_FRAMES];

    // Payload as the application feeds it, and the full expected output
    udp_tx_pkg::byte_t pay_bytes [$];
    bit                pay_lasts [$];
    udp_tx_pkg::byte_t exp_data [$];
    bit                exp_last [$];

    udp_tx_top dut (
        .clk           (clk),
        .rst           (rst),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .hdr_dest_ip   (hdr_dest_ip),
        .hdr_dest_port (hdr_dest_port),
        .hdr_length    (hdr_length),
        .pay_valid     (pay_valid),
        .pay_ready     (pay_ready),
        .pay_data      (pay_data),
        .pay_last      (pay_last),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_last      (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // IPv4 header checksum from the header words, checksum field as zero
    function automatic udp_tx_pkg::csum_t ref_checksum(udp_tx_pkg::ip_addr_t ip,
                                                       udp_tx_pkg::payload_len_t len);
        logic [31:0] s;
        s = 32'h4500 + 32'd28 + {22'd0, len} + 32'h4011 + 32'hC0A8 + 32'h0180
            + {16'd0, ip[31:16]} + {16'd0, ip[15:0]};
        s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
        s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
        return ~s[15:0];
    endfunction

    task automatic push_byte(udp_tx_pkg::byte_t b, bit last);
        exp_data.push_back(b);
        exp_last.push_back(last);
    endtask

    task automatic push_word(logic [15:0] w);
        push_byte(w[15:8], 1'b0);
        push_byte(w[7:0], 1'b0);
    endtask

    task automatic queue_expected(int k);
        udp_tx_pkg::byte_t b;
        udp_tx_pkg::csum_t cs;
        bit last;
        cs = ref_checksum(f_ip[k], f_len[k]);
        // Destination MAC 66:55:44:33:22:11, then local MAC 11:22:33:44:55:66
        for (int i = 0; i < 6; i++) begin
            push_byte(8'(102 - 17 * i), 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            push_byte(8'(17 + 17 * i), 1'b0);
        end
        push_word(16'h0800);
        push_word(16'h4500);
        push_word(16'd28 + {6'd0, f_len[k]});
        push_word(16'h0000);
        push_word(16'h0000);
        push_word({8'd64, 8'd17});
        push_word(cs);
        push_word(16'hC0A8);
        push_word(16'h0180);
        push_word(f_ip[k][31:16]);
        push_word(f_ip[k][15:0]);
        push_word(16'd1234);
        push_word(f_port[k]);
        push_word(16'd8 + {6'd0, f_len[k]});
        push_word(16'h0000);
        for (int i = 0; i < int'(f_len[k]); i++) begin
            b = 8'($random(seed));
            last = (i == int'(f_len[k]) - 1);
            pay_bytes.push_back(b);
            pay_lasts.push_back(last);
            push_byte(b, last);
        end
    endtask

    task automatic build_frames();
        for (int k = 0; k < NUM_FRAMES; k++) begin
            f_ip[k]   = $random(seed);
            f_port[k] = 16'($random(seed));
            if (k == 0) begin
                f_len[k] = 10'd1;
            end else if (k == 1) begin
                f_len[k] = 10'(MAX_LEN);
            end else begin
                f_len[k] = 10'(1 + $unsigned($random(seed)) % 120);
            end
            queue_expected(k);
        end
    endtask

    // Called on the falling edge; holds valid and data until each transfer
    task automatic drive_inputs();
        hdr_valid = (hdr_idx < NUM_FRAMES);
        if (hdr_idx < NUM_FRAMES) begin
            hdr_dest_ip   = f_ip[hdr_idx];
            hdr_dest_port = f_port[hdr_idx];
            hdr_length    = f_len[hdr_idx];
        end
        if (pay_pos < pay_bytes.size()) begin
            if (!pay_valid || pay_took) begin
                pay_valid = (($random(seed) & 3) != 0);
            end
            pay_data = pay_bytes[pay_pos];
            pay_last = pay_lasts[pay_pos];
        end else begin
            pay_valid = 1'b0;
            pay_data  = 8'h00;
            pay_last  = 1'b0;
        end
        out_ready = (($random(seed) & 3) != 0);
    endtask

    // Records the transfers that the next rising edge will perform
    task automatic observe_outputs();
        if (hdr_valid && hdr_ready) begin
            if (hdr_idx > frames_out) begin
                overlap_cnt++;
            end
            hdr_idx++;
        end
        pay_took = pay_valid && pay_ready;
        if (pay_took) begin
            pay_pos++;
        end
        if (out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("Output byte %02h arrived after all expected frames", out_data);
            end else begin
                bytes_checked++;
                assert (out_data == exp_data[0] && out_last == exp_last[0]) else begin
                    errors++;
                    $display("[FAIL] %0d ns: frame %0d byte %0d got %02h/%0b, exp %02h/%0b",
                             $time, frames_out, frame_byte, out_data, out_last,
                             exp_data[0], exp_last[0]);
                end
                void'(exp_data.pop_front());
                void'(exp_last.pop_front());
            end
            frame_byte++;
            if (out_last) begin
                frames_out++;
                frame_byte = 0;
            end
        end
    endtask

    // Output held while stalled
    a_out_stable : assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last))
    ) else begin
        errors++;
        $display("[FAIL] %0d ns: out_data or out_last changed during a stall", $time);
    end

    a_pay_ready_follows : assert property (
        @(posedge clk) disable iff (rst)
        pay_ready |-> out_ready
    ) else begin
        errors++;
        $display("[FAIL] %0d ns: pay_ready high while out_ready is low", $time);
    end

    a_last_with_valid : assert property (
        @(posedge clk) disable iff (rst)
        out_last |-> out_valid
    ) else begin
        errors++;
        $display("[FAIL] %0d ns: out_last high without out_valid", $time);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d of %0d frames out",
                 WATCHDOG_CYCLES, frames_out, NUM_FRAMES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed          = 32'h0678d4d5;
        errors        = 0;
        bytes_checked = 0;
        frames_out    = 0;
        frame_byte    = 0;
        hdr_idx       = 0;
        pay_pos       = 0;
        overlap_cnt   = 0;
        pay_took      = 1'b0;
        rst           = 1'b1;
        hdr_valid     = 1'b0;
        hdr_dest_ip   = '0;
        hdr_dest_port = '0;
        hdr_length    = '0;
        pay_valid     = 1'b0;
        pay_data      = '0;
        pay_last      = 1'b0;
        out_ready     = 1'b0;
        build_frames();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        assert (hdr_ready && !out_valid && !pay_ready) else begin
            errors++;
            $display("[FAIL] %0d ns: after reset hdr_ready %0b out_valid %0b pay_ready %0b",
                     $time, hdr_ready, out_valid, pay_ready);
        end

        while (frames_out < NUM_FRAMES) begin
            @(negedge clk);
            drive_inputs();
            #1;
            observe_outputs();
        end

        if (exp_data.size() != 0 || pay_pos != pay_bytes.size()) begin
            errors++;
            $display("Frames ended with %0d output bytes and %0d payload bytes left over",
                     exp_data.size(), pay_bytes.size() - pay_pos);
        end
        assert (overlap_cnt > 0) else begin
            errors++;
            $display("No header was accepted while an earlier frame was still going out");
        end

        $display("Frames %0d, bytes checked %0d, overlapped headers %0d, errors %0d",
                 frames_out, bytes_checked, overlap_cnt, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: udp_tx_top.sv
`timescale 1ns/100ps

module udp_tx_top (
    input  logic                      clk,
    input  logic                      rst,

    // Header request
    input  logic                      hdr_valid,
    output logic                      hdr_ready,
    input  udp_tx_pkg::ip_addr_t      hdr_dest_ip,
    input  udp_tx_pkg::udp_port_t     hdr_dest_port,
    input  udp_tx_pkg::payload_len_t  hdr_length,

    // Payload stream
    input  logic                      pay_valid,
    output logic                      pay_ready,
    input  udp_tx_pkg::byte_t         pay_data,
    input  logic                      pay_last,

    // Framed output stream
    output logic                      out_valid,
    input  logic                      out_ready,
    output udp_tx_pkg::byte_t         out_data,
    output logic                      out_last
);

    logic                      loaded;
    logic                      take;
    logic                      csum_valid;
    udp_tx_pkg::csum_t         csum;
    udp_tx_pkg::ip_addr_t      cap_dest_ip;
    udp_tx_pkg::udp_port_t     cap_dest_port;
    udp_tx_pkg::payload_len_t  cap_length;

    udp_hdr_capture u_capture (
        .clk           (clk),
        .rst           (rst),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .hdr_dest_ip   (hdr_dest_ip),
        .hdr_dest_port (hdr_dest_port),
        .hdr_length    (hdr_length),
        .take          (take),
        .loaded        (loaded),
        .cap_dest_ip   (cap_dest_ip),
        .cap_dest_port (cap_dest_port),
        .cap_length    (cap_length)
    );

    ip_checksum u_checksum (
        .clk         (clk),
        .rst         (rst),
        .loaded      (loaded),
        .cap_dest_ip (cap_dest_ip),
        .cap_length  (cap_length),
        .take        (take),
        .csum_valid  (csum_valid),
        .csum        (csum)
    );

    frame_serializer u_serializer (
        .clk           (clk),
        .rst           (rst),
        .csum_valid    (csum_valid),
        .csum          (csum),
        .cap_dest_ip   (cap_dest_ip),
        .cap_dest_port (cap_dest_port),
        .cap_length    (cap_length),
        .pay_valid     (pay_valid),
        .pay_data      (pay_data),
        .pay_last      (pay_last),
        .out_ready     (out_ready),
        .take          (take),
        .pay_ready     (pay_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_last      (out_last)
    );

endmodule

// File: frame_serializer.sv
`timescale 1ns/100ps

`include "udp_tx_defs.svh"

module frame_serializer (
    input  logic                      clk,
    input  logic                      rst,

    // From checksum and capture stages
    input  logic                      csum_valid,
    input  udp_tx_pkg::csum_t         csum,
    input  udp_tx_pkg::ip_addr_t      cap_dest_ip,
    input  udp_tx_pkg::udp_port_t     cap_dest_port,
    input  udp_tx_pkg::payload_len_t  cap_length,

    // Payload in
    input  logic                      pay_valid,
    input  udp_tx_pkg::byte_t         pay_data,
    input  logic                      pay_last,

    input  logic                      out_ready,

    output logic                      take,
    output logic                      pay_ready,
    output logic                      out_valid,
    output udp_tx_pkg::byte_t         out_data,
    output logic                      out_last
);

    localparam int HDR_BITS = `UDP_TX_FRAME_HDR_BYTES * 8;
    localparam logic [5:0] LAST_HDR_IDX = 6'(`UDP_TX_FRAME_HDR_BYTES - 1);

    udp_tx_pkg::ser_state_t    state;
    logic [5:0]                byte_idx;
    udp_tx_pkg::payload_len_t  pay_cnt;
    udp_tx_pkg::payload_len_t  pay_cnt_next;

    // Frame fields held for the whole frame
    udp_tx_pkg::ip_addr_t      dest_ip_q;
    udp_tx_pkg::udp_port_t     dest_port_q;
    udp_tx_pkg::payload_len_t  len_q;
    udp_tx_pkg::csum_t         csum_q;

    logic [15:0]               ip_total_len;
    logic [15:0]               udp_len;
    logic [HDR_BITS-1:0]       hdr;
    udp_tx_pkg::byte_t         hdr_byte;
    logic                      pay_xfer;

    assign ip_total_len = 16'(`UDP_TX_IP_HDR_BYTES + `UDP_TX_UDP_HDR_BYTES) + {6'd0, len_q};
    assign udp_len      = 16'(`UDP_TX_UDP_HDR_BYTES) + {6'd0, len_q};

    // Ethernet, IPv4 and UDP headers in wire order
    assign hdr = {
        `UDP_TX_DEST_MAC, `UDP_TX_LOCAL_MAC, `UDP_TX_ETHERTYPE_IPV4,
        4'd4, 4'd5, 8'h00, ip_total_len,
        16'h0000, 16'h0000,
        `UDP_TX_TTL, `UDP_TX_PROTO_UDP, csum_q,
        `UDP_TX_LOCAL_IP, dest_ip_q,
        `UDP_TX_SRC_PORT, dest_port_q, udp_len, 16'h0000
    };

    assign hdr_byte = hdr[(HDR_BITS - 8) - 8 * int'(byte_idx) +: 8];

    assign take         = (state == udp_tx_pkg::IDLE) && csum_valid;
    assign pay_xfer     = (state == udp_tx_pkg::PAYLOAD) && pay_valid && out_ready;
    assign pay_cnt_next = pay_cnt + 10'd1;

    always_comb begin
        out_valid = 1'b0;
        out_data  = hdr_byte;
        out_last  = 1'b0;
        pay_ready = 1'b0;
        case (state)
            udp_tx_pkg::HEADER: begin
                out_valid = 1'b1;
            end
            udp_tx_pkg::PAYLOAD: begin
                // Straight pass-through with no added latency
                out_valid = pay_valid;
                out_data  = pay_data;
                out_last  = pay_valid && pay_last;
                pay_ready = out_ready;
            end
            default: begin
                out_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= udp_tx_pkg::IDLE;
            byte_idx <= 6'd0;
            pay_cnt  <= 10'd0;
        end else begin
            case (state)
                udp_tx_pkg::IDLE: begin
                    if (csum_valid) begin
                        state    <= udp_tx_pkg::HEADER;
                        byte_idx <= 6'd0;
                    end
                end
                udp_tx_pkg::HEADER: begin
                    if (out_ready) begin
                        if (byte_idx == LAST_HDR_IDX) begin
                            state   <= udp_tx_pkg::PAYLOAD;
                            pay_cnt <= 10'd0;
                        end else begin
                            byte_idx <= byte_idx + 6'd1;
                        end
                    end
                end
                udp_tx_pkg::PAYLOAD: begin
                    if (pay_xfer) begin
                        pay_cnt <= pay_cnt_next;
                        if (pay_last) begin
                            state <= udp_tx_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    state <= udp_tx_pkg::IDLE;
                end
            endcase
        end
    end

    // Copy the captured request, which frees the capture entry
    always_ff @(posedge clk) begin
        if (take) begin
            dest_ip_q   <= cap_dest_ip;
            dest_port_q <= cap_dest_port;
            len_q       <= cap_length;
            csum_q      <= csum;
        end
    end

    // Application must end the payload exactly at the requested length
    a_last_at_length : assert property (
        @(posedge clk) disable iff (rst)
        pay_xfer |-> (pay_last == (pay_cnt_next == len_q))
    ) else $error("pay_last does not match requested payload length");

endmodule

// File: ip_checksum.sv
`timescale 1ns/100ps

`include "udp_tx_defs.svh"

module ip_checksum (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      loaded,
    input  udp_tx_pkg::ip_addr_t      cap_dest_ip,
    input  udp_tx_pkg::payload_len_t  cap_length,
    input  logic                      take,
    output logic                      csum_valid,
    output udp_tx_pkg::csum_t         csum
);

    localparam logic [3:0] LAST_WORD = 4'(`UDP_TX_IP_HDR_BYTES / 2 - 1);

    logic               busy;
    logic [3:0]         word_idx;
    logic               step;
    logic [15:0]        word;
    logic [15:0]        total_len;
    logic [16:0]        sum;
    udp_tx_pkg::csum_t  acc;

    assign total_len = 16'(`UDP_TX_IP_HDR_BYTES + `UDP_TX_UDP_HDR_BYTES) + {6'd0, cap_length};

    // Header words in order, checksum field as zero
    always_comb begin
        case (word_idx)
            4'd0:    word = {4'd4, 4'd5, 8'h00};
            4'd1:    word = total_len;
            4'd4:    word = {`UDP_TX_TTL, `UDP_TX_PROTO_UDP};
            4'd6:    word = 16'(`UDP_TX_LOCAL_IP >> 16);
            4'd7:    word = 16'(`UDP_TX_LOCAL_IP);
            4'd8:    word = cap_dest_ip[31:16];
            4'd9:    word = cap_dest_ip[15:0];
            default: word = 16'h0000;
        endcase
    end

    // First word adds onto zero
    assign step = loaded || busy;
    assign sum  = {1'b0, (loaded ? 16'h0000 : acc)} + {1'b0, word};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            word_idx   <= 4'd0;
            csum_valid <= 1'b0;
        end else begin
            if (step) begin
                if (word_idx == LAST_WORD) begin
                    busy       <= 1'b0;
                    word_idx   <= 4'd0;
                    csum_valid <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    word_idx <= word_idx + 4'd1;
                end
            end
            if (take) begin
                csum_valid <= 1'b0;
            end
        end
    end

    // End-around carry
    always_ff @(posedge clk) begin
        if (step) begin
            acc <= sum[15:0] + {15'd0, sum[16]};
        end
    end

    assign csum = ~acc;

    a_no_overlap : assert property (
        @(posedge clk) disable iff (rst)
        loaded |-> !busy && !csum_valid
    ) else $error("new header loaded while checksum still in use");

endmodule

// File: udp_hdr_capture.sv
`timescale 1ns/100ps

module udp_hdr_capture (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      hdr_valid,
    output logic                      hdr_ready,
    input  udp_tx_pkg::ip_addr_t      hdr_dest_ip,
    input  udp_tx_pkg::udp_port_t     hdr_dest_port,
    input  udp_tx_pkg::payload_len_t  hdr_length,

    // Serializer has copied the entry
    input  logic                      take,

    output logic                      loaded,
    output udp_tx_pkg::ip_addr_t      cap_dest_ip,
    output udp_tx_pkg::udp_port_t     cap_dest_port,
    output udp_tx_pkg::payload_len_t  cap_length
);

    logic full;
    logic accept;

    // Single entry, so only accept when empty
    assign hdr_ready = !full;
    assign accept    = hdr_valid && hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full   <= 1'b0;
            loaded <= 1'b0;
        end else begin
            loaded <= accept;
            if (accept) begin
                full <= 1'b1;
            end else if (take) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cap_dest_ip   <= hdr_dest_ip;
            cap_dest_port <= hdr_dest_port;
            cap_length    <= hdr_length;
        end
    end

    // Serializer may only take a header that is actually held
    a_take_when_full : assert property (
        @(posedge clk) disable iff (rst)
        take |-> full
    ) else $error("take seen while header entry is empty");

endmodule

// File: udp_tx_pkg.sv
package udp_tx_pkg;

    // One byte of the stream
    typedef logic [7:0] byte_t;

    // IPv4 address in network order
    typedef logic [31:0] ip_addr_t;

    typedef logic [15:0] udp_port_t;

    // Payload length in bytes, 1 to 1023
    typedef logic [9:0] payload_len_t;

    // Ones-complement header checksum
    typedef logic [15:0] csum_t;

    // Serializer FSM
    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } ser_state_t;

endpackage

// File: udp_tx_defs.svh
`ifndef UDP_TX_DEFS_SVH
`define UDP_TX_DEFS_SVH

// Ethernet addressing
`define UDP_TX_LOCAL_MAC        48'h11_22_33_44_55_66
`define UDP_TX_DEST_MAC         48'h66_55_44_33_22_11
`define UDP_TX_ETHERTYPE_IPV4   16'h0800

// Local IP 192.168.1.128
`define UDP_TX_LOCAL_IP         32'hC0_A8_01_80

// IPv4 fixed fields
`define UDP_TX_TTL              8'd64
`define UDP_TX_PROTO_UDP        8'd17

// UDP source port
`define UDP_TX_SRC_PORT         16'd1234

// Header sizes in bytes
`define UDP_TX_IP_HDR_BYTES     20
`define UDP_TX_UDP_HDR_BYTES    8
`define UDP_TX_FRAME_HDR_BYTES  42

`endif
